/* bench/fir_tb.sv */
`timescale 1ns/1ps

module fir_tb;
    import fir_cfg_pkg::*;

    localparam int num_taps    = num_taps_default;
    localparam int max_samples = 32;
    localparam int num_rows    = 4;
    localparam int mode_random = 0;
    localparam int mode_max    = 1;
    localparam int mode_alt    = 2;
    localparam int reg_cycles  = 400;
    localparam longint pos_lim = 64'sd2147483647;
    localparam longint neg_lim = -64'sd2147483648;

    // ================================================
    // Stimulus table
    // ================================================

    string row_name [num_rows] = '{"random_taps", "random_backpressure",
                                   "max_saturation", "alt_sign_backpressure"};
    int    row_mode [num_rows] = '{mode_random, mode_random, mode_max, mode_alt};
    int    row_count [num_rows] = '{8, 20, 12, 16};
    logic  row_bp [num_rows] = '{1'b0, 1'b1, 1'b0, 1'b1};

    logic                  axis_clk = 1'b0;
    logic                  axis_rst_n;
    logic                  awvalid;
    logic [11:0]           awaddr;
    logic                  awready;
    logic                  wvalid;
    logic [31:0]           wdata;
    logic                  wready;
    logic                  arvalid;
    logic [11:0]           araddr;
    logic                  arready;
    logic                  rvalid;
    logic [31:0]           rdata;
    logic                  rready;
    logic                  ss_tvalid;
    logic [31:0]           ss_tdata;
    logic                  ss_tlast;
    logic                  ss_tready;
    logic                  sm_tready;
    logic                  sm_tvalid;
    logic [31:0]           sm_tdata;
    logic                  sm_tlast;

    logic [31:0] tap_vals [num_taps];
    logic [31:0] sample_vals [max_samples];
    logic [31:0] lcg_state = 32'd71;
    int          errors = 0;

    always #4 axis_clk = ~axis_clk;

    fir_top #(
        .data_width (data_width_default),
        .addr_width (addr_width_default),
        .num_taps   (num_taps)
    ) dut0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [11:0] tap_addr(input int k);
        return addr_tap_base + 12'(4 * k);
    endfunction

    // ================================================
    // Reference model
    // ================================================

    function automatic longint clamp32(input longint v);
        if (v > pos_lim) return pos_lim;
        if (v < neg_lim) return neg_lim;
        return v;
    endfunction

    // Samples before the first one of the run count as zero.
    function automatic logic [31:0] model_output(input int n);
        longint      acc;
        longint      prod;
        logic [31:0] xs;
        acc = 0;
        for (int k = 0; k < num_taps; k++) begin
            xs = (n - k >= 0) ? sample_vals[n - k] : '0;
            prod = longint'($signed(tap_vals[k])) * longint'($signed(xs));
            acc = clamp32(acc + clamp32(prod));
        end
        return acc[31:0];
    endfunction

    // ================================================
    // Checks and bus tasks
    // ================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error: %s", what);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(posedge axis_clk);
        while (!(awready && wready)) @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] value);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b1;
        @(posedge axis_clk);
        while (!arready) @(posedge axis_clk);
        arvalid <= 1'b0;
        @(posedge axis_clk);
        while (!rvalid) @(posedge axis_clk);
        value = rdata;
        rready <= 1'b0;
    endtask

    task automatic fill_row(input int mode, input int count);
        logic [31:0] r;
        for (int k = 0; k < num_taps; k++) begin
            r = next_random();
            case (mode)
                mode_max: tap_vals[k] = 32'h7FFFFFFF;
                mode_alt: tap_vals[k] = k[0] ? 32'h80000000 : 32'h7FFFFFFF;
                default:  tap_vals[k] = {{16{r[31]}}, r[31:16]};
            endcase
        end
        for (int i = 0; i < count; i++) begin
            r = next_random();
            case (mode)
                mode_max: sample_vals[i] = (i < count / 2) ? 32'h7FFFFFFF : 32'h80000000;
                mode_alt: sample_vals[i] = r;
                default:  sample_vals[i] = {{16{r[31]}}, r[31:16]};
            endcase
        end
    endtask

    // Writes the length and every tap, then reads them all back.
    task automatic load_config(input string name, input int count);
        logic [31:0] value;
        write_reg(addr_data_len, 32'(count));
        for (int k = 0; k < num_taps; k++) begin
            write_reg(tap_addr(k), tap_vals[k]);
        end
        read_reg(addr_data_len, value);
        check_value({name, " length readback"}, 32'(count), value);
        for (int k = 0; k < num_taps; k++) begin
            read_reg(tap_addr(k), value);
            check_value($sformatf("%s tap %0d readback", name, k), tap_vals[k], value);
        end
    endtask

    task automatic check_refused(input string name);
        logic [31:0] value;
        write_reg(addr_ap_ctrl, 32'h1);
        read_reg(addr_ap_ctrl, value);
        check_value({name, " ctrl"}, 32'h4, value);
        ss_tvalid <= 1'b1;
        ss_tdata  <= 32'h1234;
        ss_tlast  <= 1'b1;
        repeat (16) begin
            @(posedge axis_clk);
            check_true(!ss_tready,
                       $sformatf("%s: the engine took a sample without a valid start", name));
        end
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    // ================================================
    // Stream source and sink
    // ================================================

    task automatic send_samples(input int count);
        for (int i = 0; i < count; i++) begin
            ss_tvalid <= 1'b1;
            ss_tdata  <= sample_vals[i];
            ss_tlast  <= (i == count - 1);
            @(posedge axis_clk);
            while (!ss_tready) @(posedge axis_clk);
        end
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    task automatic collect_outputs(input string name, input int count, input logic bp);
        int          got;
        logic        held_valid;
        logic [31:0] held;
        logic [31:0] r;
        got = 0;
        held_valid = 1'b0;
        held = '0;
        sm_tready <= 1'b1;
        while (got < count) begin
            @(posedge axis_clk);
            if (sm_tvalid && held_valid) begin
                check_value($sformatf("%s stalled output %0d", name, got), held, sm_tdata);
            end
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("%s output %0d", name, got), model_output(got), sm_tdata);
                check_value($sformatf("%s tlast %0d", name, got),
                            32'(got == count - 1), 32'(sm_tlast));
                got++;
                held_valid = 1'b0;
            end else if (sm_tvalid) begin
                held = sm_tdata;
                held_valid = 1'b1;
            end
            r = next_random();
            sm_tready <= bp ? r[24] : 1'b1;
        end
        sm_tready <= 1'b0;
    endtask

    // ================================================
    // Main sequence and watchdog
    // ================================================

    initial begin : main
        logic [31:0] value;
        axis_rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata = '0;
        ss_tlast = 1'b0;
        sm_tready = 1'b0;
        repeat (8) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        @(posedge axis_clk);
        check_true(!ss_tready && !sm_tvalid && !rvalid, "outputs not idle after reset");
        read_reg(addr_ap_ctrl, value);
        check_value("reset ctrl", 32'h4, value);
        read_reg(12'h004, value);
        check_value("unmapped read", 32'hFFFFFFFF, value);

        // The last tap stays unwritten, so start must be refused.
        write_reg(addr_data_len, 32'd5);
        for (int k = 0; k < num_taps - 1; k++) begin
            write_reg(tap_addr(k), 32'(k + 1));
        end
        check_refused("partial_config");

        for (int r = 0; r < num_rows; r++) begin
            fill_row(row_mode[r], row_count[r]);
            load_config(row_name[r], row_count[r]);
            write_reg(addr_ap_ctrl, 32'h1);
            fork
                send_samples(row_count[r]);
                collect_outputs(row_name[r], row_count[r], row_bp[r]);
            join
            read_reg(addr_ap_ctrl, value);
            check_value({row_name[r], " done ctrl"}, 32'h6, value);
            read_reg(addr_ap_ctrl, value);
            check_value({row_name[r], " cleared ctrl"}, 32'h4, value);
            check_refused({row_name[r], " restart"});
        end

        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 8 + reg_cycles;
        for (int r = 0; r < num_rows; r++) begin
            limit += row_count[r] * (num_taps + 10) + reg_cycles;
        end
        repeat (limit) @(posedge axis_clk);
        $display("Timeout: the run did not finish within %0d clock cycles.", limit);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule

/* filelist.f */
hdl/fir_cfg_pkg.sv
hdl/fir_ctrl_pkg.sv
hdl/sat_mac.sv
hdl/axil_regs.sv
hdl/fir_engine.sv
hdl/fir_top.sv
bench/fir_tb.sv

/* hdl/axil_regs.sv */
`timescale 1ns/1ps

module axil_regs #(
    parameter int data_width = fir_cfg_pkg::data_width_default,
    parameter int addr_width = fir_cfg_pkg::addr_width_default,
    parameter int num_taps   = fir_cfg_pkg::num_taps_default
) (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic [addr_width-1:0]       awaddr,
    output logic                        awready,
    input  logic                        wvalid,
    input  logic [data_width-1:0]       wdata,
    output logic                        wready,
    input  logic                        arvalid,
    input  logic [addr_width-1:0]       araddr,
    output logic                        arready,
    output logic                        rvalid,
    output logic [data_width-1:0]       rdata,
    input  logic                        rready,
    input  logic                        finish,
    input  logic [$clog2(num_taps)-1:0] tap_index,
    output logic [data_width-1:0]       tap_coef,
    output logic                        start
);
    import fir_cfg_pkg::*;
    import fir_ctrl_pkg::*;

    localparam int tap_w = $clog2(num_taps);
    localparam logic [addr_width-1:0] ctrl_addr = addr_width'(addr_ap_ctrl);
    localparam logic [addr_width-1:0] len_addr  = addr_width'(addr_data_len);
    localparam logic [addr_width-1:0] tap_base  = addr_width'(addr_tap_base);
    localparam logic [addr_width-1:0] tap_last  = addr_width'(addr_tap_last);

    logic [data_width-1:0] taps [num_taps];
    logic [num_taps-1:0]   tap_written;
    logic                  len_written;
    logic [data_width-1:0] data_len;
    logic                  ap_done;
    logic                  ap_idle;
    logic [addr_width-1:0] rd_addr;
    logic                  wr_fire;
    logic                  ar_fire;
    logic                  wr_tap_hit;
    logic [tap_w-1:0]      wr_tap_sel;
    logic                  rd_tap_hit;
    logic [tap_w-1:0]      rd_tap_sel;
    logic                  cfg_ready;
    logic [data_width-1:0] ctrl_word;

    // Word aligned and inside the populated part of the tap window.
    function automatic logic tap_hit(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] offset;
        offset = addr - tap_base;
        return (addr >= tap_base) && (addr <= tap_last) && (offset[1:0] == 2'b00)
            && ((offset >> 2) < num_taps);
    endfunction

    function automatic logic [tap_w-1:0] tap_sel(input logic [addr_width-1:0] addr);
        logic [addr_width-1:0] offset;
        offset = addr - tap_base;
        return offset[tap_w+1:2];
    endfunction

    assign wr_fire    = awvalid && wvalid && !awready && !wready;
    assign ar_fire    = arvalid && !arready && !rvalid;
    assign wr_tap_hit = tap_hit(awaddr);
    assign wr_tap_sel = tap_sel(awaddr);
    assign rd_tap_hit = tap_hit(rd_addr);
    assign rd_tap_sel = tap_sel(rd_addr);
    assign cfg_ready  = len_written && (&tap_written);
    assign tap_coef   = taps[tap_index];

    always_comb begin
        ctrl_word = '0;
        ctrl_word[ap_start_bit] = start;
        ctrl_word[ap_done_bit]  = ap_done;
        ctrl_word[ap_idle_bit]  = ap_idle;
    end

    // ================================================
    // Write channel
    // ================================================

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= wr_fire;
            wready  <= wr_fire;
        end
    end

    // Start gate and status bits.
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            start       <= 1'b0;
            ap_idle     <= 1'b1;
            ap_done     <= 1'b0;
            len_written <= 1'b0;
            tap_written <= '0;
        end else begin
            start <= 1'b0;
            if (wr_fire && ap_idle) begin
                if (awaddr == ctrl_addr && wdata[ap_start_bit] && cfg_ready) begin
                    start   <= 1'b1;
                    ap_idle <= 1'b0;
                end
                if (awaddr == len_addr) begin
                    len_written <= 1'b1;
                end
                if (wr_tap_hit) begin
                    tap_written[wr_tap_sel] <= 1'b1;
                end
            end
            if (rvalid && rready && rd_addr == ctrl_addr) begin
                ap_done <= 1'b0;
            end
            // A finished run wants a fresh configuration.
            if (finish) begin
                ap_done     <= 1'b1;
                ap_idle     <= 1'b1;
                len_written <= 1'b0;
                tap_written <= '0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_fire && ap_idle) begin
            if (awaddr == len_addr) begin
                data_len <= wdata;
            end
            if (wr_tap_hit) begin
                taps[wr_tap_sel] <= wdata;
            end
        end
    end

    // ================================================
    // Read channel
    // ================================================

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ar_fire;
            if (arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
        if (arready) begin
            if (rd_addr == ctrl_addr) begin
                rdata <= ctrl_word;
            end else if (rd_addr == len_addr) begin
                rdata <= data_len;
            end else if (rd_tap_hit) begin
                rdata <= taps[rd_tap_sel];
            end else begin
                rdata <= '1;
            end
        end
    end

endmodule

/* hdl/fir_cfg_pkg.sv */
package fir_cfg_pkg;

    // ================================================
    // Default sizes
    // ================================================

    // Sample and coefficient width in bits.
    localparam int data_width_default = 32;

    // Register port address width in bits.
    localparam int addr_width_default = 12;

    // Number of filter taps.
    localparam int num_taps_default = 11;

    // ================================================
    // Register map
    // ================================================

    // Control word holding ap_start, ap_done and ap_idle.
    localparam logic [11:0] addr_ap_ctrl = 12'h000;

    // Data length, stored and read back only.
    localparam logic [11:0] addr_data_len = 12'h010;

    // First tap coefficient, one word per tap.
    localparam logic [11:0] addr_tap_base = 12'h020;

    // End of the tap window.
    localparam logic [11:0] addr_tap_last = 12'h0FF;

endpackage

/* hdl/fir_ctrl_pkg.sv */
package fir_ctrl_pkg;

    // Engine states for one sample at a time.
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_fetch  = 3'd1,
        st_calc   = 3'd2,
        st_out    = 3'd3,
        st_finish = 3'd4
    } engine_state_t;

    // ================================================
    // Control word bit positions
    // ================================================

    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

endpackage

/* hdl/fir_engine.sv */
`timescale 1ns/1ps

module fir_engine #(
    parameter int data_width = fir_cfg_pkg::data_width_default,
    parameter int num_taps   = fir_cfg_pkg::num_taps_default
) (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        start,
    input  logic                        ss_tvalid,
    input  logic [data_width-1:0]       ss_tdata,
    input  logic                        ss_tlast,
    output logic                        ss_tready,
    input  logic                        sm_tready,
    output logic                        sm_tvalid,
    output logic [data_width-1:0]       sm_tdata,
    output logic                        sm_tlast,
    output logic                        finish,
    output logic [$clog2(num_taps)-1:0] tap_index,
    output logic                        mac_clear,
    output logic                        mac_en,
    output logic [data_width-1:0]       mac_sample,
    output logic [data_width-1:0]       mac_coef,
    input  logic [data_width-1:0]       mac_acc,
    input  logic [data_width-1:0]       tap_coef
);
    import fir_ctrl_pkg::*;

    localparam int tap_w = $clog2(num_taps);
    localparam int cnt_w = $clog2(num_taps + 2);
    localparam logic [cnt_w-1:0] k_taps = cnt_w'(num_taps);
    localparam logic [cnt_w-1:0] k_last = cnt_w'(num_taps + 1);
    localparam logic [tap_w-1:0] ptr_top = tap_w'(num_taps - 1);

    engine_state_t         state;
    engine_state_t         state_next;
    logic [data_width-1:0] ring [num_taps];
    logic [tap_w-1:0]      newest;
    logic [tap_w-1:0]      newest_next;
    logic [tap_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      k;
    logic                  last_q;
    logic                  take;
    logic                  capture;

    assign ss_tready   = (state == st_fetch);
    assign take        = ss_tvalid && ss_tready;
    assign finish      = (state == st_finish);
    assign capture     = (state == st_calc) && (k == k_last);
    assign newest_next = (newest == ptr_top) ? '0 : newest + 1'b1;
    // Past the last tap the index parks at zero.
    assign tap_index   = (k < k_taps) ? k[tap_w-1:0] : '0;

    // ================================================
    // State machine
    // ================================================

    always_comb begin
        state_next = state;
        case (state)
            st_idle:   if (start) state_next = st_fetch;
            st_fetch:  if (take) state_next = st_calc;
            st_calc:   if (k == k_last) state_next = st_out;
            st_out:    if (sm_tready) state_next = last_q ? st_finish : st_fetch;
            st_finish: state_next = st_idle;
            default:   state_next = st_idle;
        endcase
    end

    // Operands are registered, so the walk runs two steps past the last tap.
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state     <= st_idle;
            k         <= '0;
            newest    <= ptr_top;
            rd_ptr    <= '0;
            last_q    <= 1'b0;
            mac_clear <= 1'b0;
            mac_en    <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            state     <= state_next;
            mac_clear <= take;
            mac_en    <= (state == st_calc) && (k < k_taps);
            if (state == st_idle && start) begin
                newest <= ptr_top;
            end
            if (take) begin
                newest <= newest_next;
                rd_ptr <= newest_next;
                last_q <= ss_tlast;
                k      <= '0;
            end else if (state == st_calc) begin
                k      <= k + 1'b1;
                rd_ptr <= (rd_ptr == '0) ? ptr_top : rd_ptr - 1'b1;
            end
            if (capture) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= last_q;
            end else if (state == st_out && sm_tready) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
            end
        end
    end

    // ================================================
    // History ring and datapath
    // ================================================

    always_ff @(posedge axis_clk) begin
        if (state == st_idle && start) begin
            for (int i = 0; i < num_taps; i++) begin
                ring[i] <= '0;
            end
        end else if (take) begin
            ring[newest_next] <= ss_tdata;
        end
        mac_sample <= ring[rd_ptr];
        mac_coef   <= tap_coef;
        if (capture) begin
            sm_tdata <= mac_acc;
        end
    end

endmodule

/* hdl/fir_top.sv */
`timescale 1ns/1ps

module fir_top #(
    parameter int data_width = fir_cfg_pkg::data_width_default,
    parameter int addr_width = fir_cfg_pkg::addr_width_default,
    parameter int num_taps   = fir_cfg_pkg::num_taps_default
) (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  awvalid,
    input  logic [addr_width-1:0] awaddr,
    output logic                  awready,
    input  logic                  wvalid,
    input  logic [data_width-1:0] wdata,
    output logic                  wready,
    input  logic                  arvalid,
    input  logic [addr_width-1:0] araddr,
    output logic                  arready,
    output logic                  rvalid,
    output logic [data_width-1:0] rdata,
    input  logic                  rready,
    input  logic                  ss_tvalid,
    input  logic [data_width-1:0] ss_tdata,
    input  logic                  ss_tlast,
    output logic                  ss_tready,
    input  logic                  sm_tready,
    output logic                  sm_tvalid,
    output logic [data_width-1:0] sm_tdata,
    output logic                  sm_tlast
);
    logic                        start;
    logic                        finish;
    logic [$clog2(num_taps)-1:0] tap_index;
    logic [data_width-1:0]       tap_coef;
    logic                        mac_clear;
    logic                        mac_en;
    logic [data_width-1:0]       mac_sample;
    logic [data_width-1:0]       mac_coef;
    logic [data_width-1:0]       mac_acc;

    // Register file, tap store and start gate.
    axil_regs #(
        .data_width (data_width),
        .addr_width (addr_width),
        .num_taps   (num_taps)
    ) u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .finish     (finish),
        .tap_index  (tap_index),
        .tap_coef   (tap_coef),
        .start      (start)
    );

    fir_engine #(
        .data_width (data_width),
        .num_taps   (num_taps)
    ) u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .finish     (finish),
        .tap_index  (tap_index),
        .mac_clear  (mac_clear),
        .mac_en     (mac_en),
        .mac_sample (mac_sample),
        .mac_coef   (mac_coef),
        .mac_acc    (mac_acc),
        .tap_coef   (tap_coef)
    );

    sat_mac #(
        .data_width (data_width)
    ) u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .mac_clear  (mac_clear),
        .mac_en     (mac_en),
        .mac_sample (mac_sample),
        .mac_coef   (mac_coef),
        .mac_acc    (mac_acc)
    );

endmodule

/* hdl/sat_mac.sv */
`timescale 1ns/1ps

module sat_mac #(
    parameter int data_width = fir_cfg_pkg::data_width_default
) (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  mac_clear,
    input  logic                  mac_en,
    input  logic [data_width-1:0] mac_sample,
    input  logic [data_width-1:0] mac_coef,
    output logic [data_width-1:0] mac_acc
);
    localparam logic [data_width-1:0] sat_max = {1'b0, {(data_width-1){1'b1}}};
    localparam logic [data_width-1:0] sat_min = {1'b1, {(data_width-1){1'b0}}};

    logic signed [2*data_width-1:0] prod_full;
    logic                           prod_ovf;
    logic [data_width-1:0]          prod_sat;
    logic [data_width:0]            sum_full;
    logic                           sum_ovf;
    logic [data_width-1:0]          sum_sat;

    // ================================================
    // Saturating multiply
    // ================================================

    assign prod_full = $signed(mac_sample) * $signed(mac_coef);
    // Upper half plus the result sign bit must all agree.
    assign prod_ovf  = prod_full[2*data_width-1:data_width-1]
                       != {(data_width+1){prod_full[2*data_width-1]}};
    assign prod_sat  = prod_ovf ? (prod_full[2*data_width-1] ? sat_min : sat_max)
                                : prod_full[data_width-1:0];

    // ================================================
    // Saturating accumulate
    // ================================================

    assign sum_full = {mac_acc[data_width-1], mac_acc} + {prod_sat[data_width-1], prod_sat};
    assign sum_ovf  = sum_full[data_width] ^ sum_full[data_width-1];
    assign sum_sat  = sum_ovf ? (sum_full[data_width] ? sat_min : sat_max)
                              : sum_full[data_width-1:0];

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            mac_acc <= '0;
        end else if (mac_clear) begin
            mac_acc <= '0;
        end else if (mac_en) begin
            mac_acc <= sum_sat;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fir_tb -f filelist.f -o fir_sim \
    && ./obj_dir/fir_sim > sim.log 2>&1

[ -f sim.log ] || { echo "No simulation log, the build failed."; exit 1; }
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed."; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
exit 0
